// File: execute_defines.svh
// shared widths and limits for the execute stage, include in any file that sizes a word or tag
`ifndef EXECUTE_DEFINES_SVH
`define EXECUTE_DEFINES_SVH

// data path

`define WORD_W 32 // data and address width

// scoreboard tags

`define REG_W 5 // destination register tag width

// memory side

// upper bound in cycles from a dmem request to its dhit,
// shared by the load/store assertion and the testbench wait loops
`define MEM_TIMEOUT 16

`endif

// File: execute_pkg.sv
// types shared by the execute stage units, imported by each module that needs an enum
package execute_pkg;

    // scalar alu operations
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_sra = 4'd7,
        alu_slt = 4'd8  // signed compare
    } aluop_t;

    // branch unit operation
    typedef enum logic [2:0] {
        br_beq  = 3'd0,
        br_bne  = 3'd1,
        br_blt  = 3'd2,
        br_bge  = 3'd3,
        br_jal  = 3'd4, // pc relative jump
        br_jalr = 3'd5  // register indirect jump
    } branch_t;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_type_t;

    // scalar load/store fsm
    typedef enum logic [1:0] {
        ls_idle   = 2'd0,
        ls_access = 2'd1, // request held until dhit
        ls_done   = 2'd2  // one cycle completion
    } ls_state_t;

endpackage

// File: fu_alu.sv
// scalar alu unit, result and flags are valid one cycle after the enable pulse
`include "execute_defines.svh"

module fu_alu
    import execute_pkg::*;
(
    input  logic               CLK,
    input  logic               reset,
    input  logic               enable,
    input  aluop_t             aluop,
    input  logic [`WORD_W-1:0] port_a,
    input  logic [`WORD_W-1:0] port_b,
    output logic [`WORD_W-1:0] port_output,
    output logic               zero,
    output logic               negative,
    output logic               overflow
);

    localparam int SH_W = $clog2(`WORD_W); // shift amount bits

    logic [`WORD_W-1:0] result; // combinational result
    logic               ovf;    // signed overflow, add and sub only
    logic [SH_W-1:0]    shamt;

    assign shamt = port_b[SH_W-1:0]; // low bits of b only

    always_comb begin
        result = '0;
        ovf    = 1'b0;
        case (aluop)
            alu_add: begin
                result = port_a + port_b;
                ovf    = (port_a[`WORD_W-1] == port_b[`WORD_W-1]) &&
                         (result[`WORD_W-1] != port_a[`WORD_W-1]); // same signs in, flip out
            end
            alu_sub: begin
                result = port_a - port_b;
                ovf    = (port_a[`WORD_W-1] != port_b[`WORD_W-1]) &&
                         (result[`WORD_W-1] != port_a[`WORD_W-1]); // signs differ, sign of a lost
            end
            alu_and: result = port_a & port_b;
            alu_or:  result = port_a | port_b;
            alu_xor: result = port_a ^ port_b;
            alu_sll: result = port_a << shamt;
            alu_srl: result = port_a >> shamt;
            alu_sra: result = $signed(port_a) >>> shamt; // sign fill
            alu_slt: result = {{(`WORD_W-1){1'b0}}, ($signed(port_a) < $signed(port_b))};
            default: result = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            zero     <= 1'b0;
            negative <= 1'b0;
            overflow <= 1'b0;
        end else if (enable) begin
            zero     <= (result == '0);
            negative <= result[`WORD_W-1];
            overflow <= ovf;
        end
    end

    always_ff @(posedge CLK) begin
        if (enable) begin
            port_output <= result; // held until next op
        end
    end

    // an issued op must carry a defined opcode
    a_aluop_known: assert property (@(posedge CLK) disable iff (reset)
        enable |-> aluop inside {alu_add, alu_sub, alu_and, alu_or, alu_xor,
                                 alu_sll, alu_srl, alu_sra, alu_slt})
        else $error("fu_alu: undefined aluop %0d issued", aluop);

endmodule

// File: fu_branch.sv
// branch and jump resolution, reports outcome, corrected pc and mispredict one cycle after enable
`include "execute_defines.svh"

module fu_branch
    import execute_pkg::*;
(
    input  logic               CLK,
    input  logic               reset,
    input  logic               enable,
    input  branch_t            branch_type,
    input  logic [`WORD_W-1:0] reg_a,
    input  logic [`WORD_W-1:0] reg_b,
    input  logic [`WORD_W-1:0] current_pc,
    input  logic [`WORD_W-1:0] imm,
    input  logic               predicted_outcome,
    output logic               resolved,
    output logic               miss,
    output logic               branch_outcome,
    output logic [`WORD_W-1:0] correct_pc,
    output logic [`WORD_W-1:0] jump_wdat
);

    logic               taken;    // resolved direction
    logic [`WORD_W-1:0] target;   // taken destination
    logic [`WORD_W-1:0] pc_plus4; // fall through, also link value
    logic [`WORD_W-1:0] jalr_sum;

    always_comb begin
        case (branch_type)
            br_beq:  taken = (reg_a == reg_b);
            br_bne:  taken = (reg_a != reg_b);
            br_blt:  taken = ($signed(reg_a) < $signed(reg_b));
            br_bge:  taken = ($signed(reg_a) >= $signed(reg_b));
            default: taken = 1'b1; // jal and jalr always go
        endcase
    end

    assign pc_plus4 = current_pc + 4;
    assign jalr_sum = reg_a + imm;

    // jalr drops bit 0 of the sum, everything else is pc relative
    assign target = (branch_type == br_jalr) ? {jalr_sum[`WORD_W-1:1], 1'b0}
                                             : current_pc + imm;

    // status pulses, one cycle per resolved op
    always_ff @(posedge CLK) begin
        if (reset) begin
            resolved <= 1'b0;
            miss     <= 1'b0;
        end else begin
            resolved <= enable;
            miss     <= enable && (taken != predicted_outcome); // jumps predicted taken never miss
        end
    end

    // results held until the next branch
    always_ff @(posedge CLK) begin
        if (enable) begin
            branch_outcome <= taken;
            correct_pc     <= taken ? target : pc_plus4;
            jump_wdat      <= pc_plus4; // link address
        end
    end

endmodule

// File: fu_scalar_ls.sv
// scalar load/store unit, holds the dmem request until dhit and pulses done the cycle after
`include "execute_defines.svh"

module fu_scalar_ls
    import execute_pkg::*;
(
    input  logic               CLK,
    input  logic               reset,
    input  logic               enable,
    input  mem_type_t          mem_type,
    input  logic [`WORD_W-1:0] rs1,
    input  logic [`WORD_W-1:0] rs2,
    input  logic [`WORD_W-1:0] imm,
    input  logic [`WORD_W-1:0] dmem_load,
    input  logic               dhit,
    output logic [`WORD_W-1:0] dmem_addr,
    output logic               dmem_ren,
    output logic               dmem_wen,
    output logic [`WORD_W-1:0] dmem_store,
    output logic [`WORD_W-1:0] load_data,
    output logic               done
);

    ls_state_t          state, next_state;
    mem_type_t          type_q;  // kind of access in flight
    logic [`WORD_W-1:0] addr_q;
    logic [`WORD_W-1:0] store_q;
    logic [`WORD_W-1:0] load_q;
    logic               start;   // new op accepted this cycle
    logic               req;     // request visible to memory

    assign start = enable && (state != ls_access); // done cycle may take the next op

    always_comb begin
        next_state = state;
        case (state)
            ls_idle, ls_done: begin
                if (enable) begin
                    next_state = (mem_type == mem_none) ? ls_done : ls_access; // no-op skips memory
                end else begin
                    next_state = ls_idle;
                end
            end
            ls_access: if (dhit) next_state = ls_done;
            default:   next_state = ls_idle;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state  <= ls_idle;
            type_q <= mem_none;
        end else begin
            state <= next_state;
            if (start) type_q <= mem_type;
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            addr_q  <= rs1 + imm; // effective address
            store_q <= rs2;
        end
        if (state == ls_access && dhit) begin
            load_q <= dmem_load; // sampled on the hit pulse
        end
    end

    assign dmem_ren   = (state == ls_access) && (type_q == mem_load);
    assign dmem_wen   = (state == ls_access) && (type_q == mem_store);
    assign dmem_addr  = addr_q;
    assign dmem_store = store_q;
    assign load_data  = load_q;
    assign done       = (state == ls_done);
    assign req        = dmem_ren || dmem_wen;

    // memory must answer every new request in bounded time
    a_dhit_timeout: assert property (@(posedge CLK) disable iff (reset)
        $rose(req) |-> ##[0:`MEM_TIMEOUT] dhit)
        else $error("fu_scalar_ls: no dhit within %0d cycles", `MEM_TIMEOUT);

endmodule

// File: execute_ctrl.sv
// execute control, tracks per-unit tags, load/store busy, spec squash and the fu_ex done vector
`include "execute_defines.svh"

module execute_ctrl (
    input  logic              CLK,
    input  logic              reset,
    input  logic              salu_enable,
    input  logic              spec,
    input  logic              bfu_enable,
    input  logic              is_jump,
    input  logic              sls_enable,
    input  logic              sls_is_load,
    input  logic [`REG_W-1:0] rd,
    input  logic              bfu_miss,
    input  logic              ls_done,
    output logic              alu_wen,
    output logic [`REG_W-1:0] alu_rd,
    output logic              jump_wen,
    output logic [`REG_W-1:0] jump_rd,
    output logic              ls_wen,
    output logic [`REG_W-1:0] ls_rd,
    output logic [2:0]        fu_ex,
    output logic              sls_busy
);

    logic alu_v_q;   // alu result valid this cycle
    logic alu_spec_q;
    logic br_v_q;    // branch resolved this cycle
    logic jump_q;    // resolved op links a register
    logic ls_load_q; // outstanding op is a load
    logic busy_q;    // load/store op outstanding

    always_ff @(posedge CLK) begin
        if (reset) begin
            alu_v_q <= 1'b0;
            br_v_q  <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            alu_v_q <= salu_enable;
            br_v_q  <= bfu_enable;
            if (sls_enable) busy_q <= 1'b1;    // new op wins over a finishing one
            else if (ls_done) busy_q <= 1'b0;
        end
    end

    // tags and flags, captured per unit on issue
    always_ff @(posedge CLK) begin
        if (salu_enable) begin
            alu_rd     <= rd;
            alu_spec_q <= spec;
        end
        if (bfu_enable) begin
            jump_rd <= rd;
            jump_q  <= is_jump;
        end
        if (sls_enable) begin
            ls_rd     <= rd; // held until ls_done
            ls_load_q <= sls_is_load;
        end
    end

    assign alu_wen  = alu_v_q && !(alu_spec_q && bfu_miss); // squash wrong-path result
    assign jump_wen = br_v_q && jump_q;
    assign ls_wen   = ls_done && ls_load_q;                 // stores write nothing back
    assign fu_ex    = {br_v_q, ls_done, alu_v_q};
    assign sls_busy = busy_q && !ls_done;                   // drops in the done cycle

    // scoreboard must hold off while the unit is busy
    a_no_issue_busy: assert property (@(posedge CLK) disable iff (reset)
        sls_enable |-> !sls_busy)
        else $error("execute_ctrl: sls_enable while sls_busy");

endmodule

// File: execute.sv
// execute stage top, connects control, alu, branch unit and scalar load/store to the scoreboard
`include "execute_defines.svh"

module execute
    import execute_pkg::*;
(
    input  logic               CLK,
    input  logic               reset,
    input  logic               salu_enable,          // from sb
    input  aluop_t             salu_aluop,
    input  logic [`WORD_W-1:0] salu_port_a,
    input  logic [`WORD_W-1:0] salu_port_b,
    input  logic               spec,                 // alu op shadowed by a branch
    input  logic               bfu_enable,           // from sb
    input  branch_t            bfu_branch_type,
    input  logic [`WORD_W-1:0] bfu_reg_a,
    input  logic [`WORD_W-1:0] bfu_reg_b,
    input  logic [`WORD_W-1:0] bfu_current_pc,
    input  logic [`WORD_W-1:0] bfu_imm,
    input  logic               bfu_predicted_outcome,
    input  logic               sls_enable,           // from sb
    input  mem_type_t          sls_mem_type,
    input  logic [`WORD_W-1:0] sls_rs1,
    input  logic [`WORD_W-1:0] sls_rs2,
    input  logic [`WORD_W-1:0] sls_imm,
    input  logic [`REG_W-1:0]  rd,
    input  logic [`WORD_W-1:0] dmem_load,            // from mem
    input  logic               dhit,
    output logic [`WORD_W-1:0] alu_wdat,             // to wb
    output logic               alu_wen,
    output logic [`REG_W-1:0]  alu_rd,
    output logic               salu_zero,
    output logic               salu_negative,
    output logic               salu_overflow,
    output logic [`WORD_W-1:0] ls_wdat,              // to wb
    output logic               ls_wen,
    output logic [`REG_W-1:0]  ls_rd,
    output logic [`WORD_W-1:0] jump_wdat,            // to wb
    output logic               jump_wen,
    output logic [`REG_W-1:0]  jump_rd,
    output logic               bfu_resolved,         // to fetch and sb
    output logic               bfu_miss,
    output logic [`WORD_W-1:0] bfu_correct_pc,
    output logic               bfu_branch_outcome,
    output logic [`WORD_W-1:0] dmem_addr,            // to mem
    output logic               dmem_ren,
    output logic               dmem_wen,
    output logic [`WORD_W-1:0] dmem_store,
    output logic [2:0]         fu_ex,                // to sb
    output logic               sls_busy
);

    logic ls_done; // load/store completion into control

    execute_ctrl i_ctrl (
        .CLK         (CLK),
        .reset       (reset),
        .salu_enable (salu_enable),
        .spec        (spec),
        .bfu_enable  (bfu_enable),
        .is_jump     (bfu_branch_type inside {br_jal, br_jalr}),
        .sls_enable  (sls_enable),
        .sls_is_load (sls_mem_type == mem_load),
        .rd          (rd),
        .bfu_miss    (bfu_miss),
        .ls_done     (ls_done),
        .alu_wen     (alu_wen),
        .alu_rd      (alu_rd),
        .jump_wen    (jump_wen),
        .jump_rd     (jump_rd),
        .ls_wen      (ls_wen),
        .ls_rd       (ls_rd),
        .fu_ex       (fu_ex),
        .sls_busy    (sls_busy)
    );

    fu_alu i_alu (
        .CLK         (CLK),
        .reset       (reset),
        .enable      (salu_enable),
        .aluop       (salu_aluop),
        .port_a      (salu_port_a),
        .port_b      (salu_port_b),
        .port_output (alu_wdat),
        .zero        (salu_zero),
        .negative    (salu_negative),
        .overflow    (salu_overflow)
    );

    fu_branch i_branch (
        .CLK               (CLK),
        .reset             (reset),
        .enable            (bfu_enable),
        .branch_type       (bfu_branch_type),
        .reg_a             (bfu_reg_a),
        .reg_b             (bfu_reg_b),
        .current_pc        (bfu_current_pc),
        .imm               (bfu_imm),
        .predicted_outcome (bfu_predicted_outcome),
        .resolved          (bfu_resolved),
        .miss              (bfu_miss),
        .branch_outcome    (bfu_branch_outcome),
        .correct_pc        (bfu_correct_pc),
        .jump_wdat         (jump_wdat)
    );

    fu_scalar_ls i_ls (
        .CLK        (CLK),
        .reset      (reset),
        .enable     (sls_enable),
        .mem_type   (sls_mem_type),
        .rs1        (sls_rs1),
        .rs2        (sls_rs2),
        .imm        (sls_imm),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .dmem_addr  (dmem_addr),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_store (dmem_store),
        .load_data  (ls_wdat),
        .done       (ls_done)
    );

endmodule

// File: tb_execute.sv
// random-stimulus testbench for the execute stage, compiled with sim.f and run by the Makefile
`include "execute_defines.svh"

module tb_execute
    import execute_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic               CLK = 1'b0;
    logic               reset;
    logic               salu_enable, spec, bfu_enable, sls_enable, bfu_predicted_outcome;
    aluop_t             salu_aluop;
    branch_t            bfu_branch_type;
    mem_type_t          sls_mem_type;
    logic [`WORD_W-1:0] salu_port_a, salu_port_b, bfu_reg_a, bfu_reg_b;
    logic [`WORD_W-1:0] bfu_current_pc, bfu_imm, sls_rs1, sls_rs2, sls_imm;
    logic [`REG_W-1:0]  rd;
    logic [`WORD_W-1:0] dmem_load;
    logic               dhit;
    logic [`WORD_W-1:0] alu_wdat, ls_wdat, jump_wdat, bfu_correct_pc, dmem_addr, dmem_store;
    logic               alu_wen, ls_wen, jump_wen, salu_zero, salu_negative, salu_overflow;
    logic [`REG_W-1:0]  alu_rd, ls_rd, jump_rd;
    logic               bfu_resolved, bfu_miss, bfu_branch_outcome;
    logic               dmem_ren, dmem_wen, sls_busy;
    logic [2:0]         fu_ex;

    // model state, one slot per unit since alu and branch latency is fixed
    logic               exp_alu_v = 1'b0, exp_alu_spec, exp_alu_ovf;
    logic [`WORD_W-1:0] exp_alu_res;
    logic [`REG_W-1:0]  exp_alu_rd;
    logic               exp_br_v = 1'b0, exp_br_taken, exp_br_miss, exp_br_jump;
    logic [`WORD_W-1:0] exp_br_pc, exp_br_link;
    logic [`REG_W-1:0]  exp_br_rd;
    logic               ls_pend = 1'b0, ls_load_e;
    logic [`WORD_W-1:0] ls_addr_e, ls_store_e, ls_data_e;
    logic [`REG_W-1:0]  ls_rd_e;
    logic [`WORD_W-1:0] model_mem [16]; // model copy of memory
    logic [`WORD_W-1:0] resp_mem [16];  // responder copy
    logic               hit_q = 1'b0;   // dhit seen at the last rising edge
    int                 hit_delay = 0;
    int                 ls_age, squash_cnt = 0, cyc;
    int                 err_word = 0, err_tag = 0, err_bit = 0, err_other = 0;
    logic               timed_out = 1'b0;

    execute i_execute (.*);

    always #4 CLK = ~CLK; // 8 ns period

    always @(posedge CLK) hit_q <= dhit;

    // memory responder, answers each request after 1 to 6 cycles
    always @(negedge CLK) begin
        dhit = 1'b0;
        if (reset) begin
            hit_delay = 0;
            for (int i = 0; i < 16; i++) resp_mem[i] = fill_word(i);
        end else if (dmem_ren || dmem_wen) begin
            if (hit_delay == 0) hit_delay = $urandom_range(1, 6); // new request
            hit_delay = hit_delay - 1;
            if (hit_delay == 0) begin
                dhit = 1'b1;
                dmem_load = resp_mem[dmem_addr[5:2]];
                if (dmem_wen) resp_mem[dmem_addr[5:2]] = dmem_store;
            end
        end
    end

    function automatic logic [`WORD_W-1:0] fill_word(int i);
        return `WORD_W'(32'h5a00_0000 | (i * 32'h0001_0203)); // distinct per index
    endfunction

    function automatic logic [`WORD_W-1:0] alu_ref(aluop_t op, logic [`WORD_W-1:0] a,
                                                   logic [`WORD_W-1:0] b);
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << (b % `WORD_W);
            alu_srl: return a >> (b % `WORD_W);
            alu_sra: return $signed(a) >>> (b % `WORD_W);
            default: return `WORD_W'($signed(a) < $signed(b)); // slt
        endcase
    endfunction

    // overflow from a one bit wider sum
    function automatic logic alu_ovf_ref(aluop_t op, logic [`WORD_W-1:0] a,
                                         logic [`WORD_W-1:0] b);
        logic [`WORD_W:0] wide;
        if (op == alu_add) wide = {a[`WORD_W-1], a} + {b[`WORD_W-1], b};
        else if (op == alu_sub) wide = {a[`WORD_W-1], a} - {b[`WORD_W-1], b};
        else return 1'b0;
        return wide[`WORD_W] != wide[`WORD_W-1];
    endfunction

    function automatic logic branch_taken(branch_t t, logic [`WORD_W-1:0] a,
                                          logic [`WORD_W-1:0] b);
        case (t)
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return $signed(a) < $signed(b);
            br_bge:  return !($signed(a) < $signed(b));
            default: return 1'b1; // jumps
        endcase
    endfunction

    task automatic check_word(string name, logic [`WORD_W-1:0] exp, logic [`WORD_W-1:0] act);
        if (exp !== act) begin
            err_word++;
            $display("Error %s at %0t: expected %h, actual %h", name, $time, exp, act);
        end
    endtask

    task automatic check_tag(string name, logic [`REG_W-1:0] exp, logic [`REG_W-1:0] act);
        if (exp !== act) begin
            err_tag++;
            $display("Error %s at %0t: expected %0d, actual %0d", name, $time, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            err_bit++;
            $display("Error %s at %0t: expected %b, actual %b", name, $time, exp, act);
        end
    endtask

    task automatic check_reset_state();
        check_bit("reset_alu_wen", 1'b0, alu_wen);
        check_bit("reset_ls_wen", 1'b0, ls_wen);
        check_bit("reset_jump_wen", 1'b0, jump_wen);
        check_bit("reset_fu_ex", 1'b0, |fu_ex);
        check_bit("reset_dmem_ren", 1'b0, dmem_ren);
        check_bit("reset_dmem_wen", 1'b0, dmem_wen);
        check_bit("reset_sls_busy", 1'b0, sls_busy);
        check_bit("reset_bfu_resolved", 1'b0, bfu_resolved);
    endtask

    task automatic check_alu();
        logic squash;
        squash = exp_alu_v && exp_alu_spec && exp_br_v && exp_br_miss; // wrong-path result
        check_bit("alu_done", exp_alu_v, fu_ex[0]);
        check_bit("alu_wen", exp_alu_v && !squash, alu_wen);
        if (exp_alu_v) begin
            if (squash) squash_cnt++;
            check_word("alu_wdat", exp_alu_res, alu_wdat);
            check_tag("alu_rd", exp_alu_rd, alu_rd);
            check_bit("alu_zero", exp_alu_res == '0, salu_zero);
            check_bit("alu_negative", exp_alu_res[`WORD_W-1], salu_negative);
            check_bit("alu_overflow", exp_alu_ovf, salu_overflow);
        end
    endtask

    task automatic check_branch();
        check_bit("bfu_resolved", exp_br_v, bfu_resolved);
        check_bit("bfu_done", exp_br_v, fu_ex[2]);
        check_bit("bfu_miss", exp_br_v && exp_br_miss, bfu_miss);
        check_bit("jump_wen", exp_br_v && exp_br_jump, jump_wen);
        if (exp_br_v) begin
            check_bit("bfu_outcome", exp_br_taken, bfu_branch_outcome);
            check_word("bfu_correct_pc", exp_br_pc, bfu_correct_pc);
            check_word("jump_wdat", exp_br_link, jump_wdat);
            if (exp_br_jump) check_tag("jump_rd", exp_br_rd, jump_rd);
        end
    endtask

    task automatic check_ls();
        if (!ls_pend) begin
            check_bit("ls_idle_done", 1'b0, fu_ex[1]);
            check_bit("ls_idle_wen", 1'b0, ls_wen);
            check_bit("ls_idle_busy", 1'b0, sls_busy);
            check_bit("ls_idle_req", 1'b0, dmem_ren || dmem_wen);
            return;
        end
        ls_age++;
        check_bit("ls_done", hit_q, fu_ex[1]); // done exactly one cycle after dhit
        if (fu_ex[1]) begin
            check_bit("ls_wen", ls_load_e, ls_wen);
            check_bit("ls_busy_done", 1'b0, sls_busy);
            if (ls_load_e) begin
                check_word("ls_wdat", ls_data_e, ls_wdat);
                check_tag("ls_rd", ls_rd_e, ls_rd);
            end
            ls_pend = 1'b0;
        end else begin
            check_bit("ls_busy", 1'b1, sls_busy);
            check_bit("dmem_ren", ls_load_e, dmem_ren);
            check_bit("dmem_wen", !ls_load_e, dmem_wen);
            check_word("dmem_addr", ls_addr_e, dmem_addr);
            if (!ls_load_e) check_word("dmem_store", ls_store_e, dmem_store);
            if (ls_age > `MEM_TIMEOUT) begin
                $display("timeout: load/store op not done after %0d cycles", ls_age);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic drive_random();
        salu_enable = ($urandom_range(0, 3) != 0);
        salu_aluop  = aluop_t'(4'($urandom_range(0, 8)));
        salu_port_a = `WORD_W'($urandom);
        salu_port_b = ($urandom_range(0, 4) == 0) ? salu_port_a : `WORD_W'($urandom);
        spec        = 1'($urandom_range(0, 1));
        bfu_enable  = ($urandom_range(0, 2) != 0);
        bfu_branch_type = branch_t'(3'($urandom_range(0, 5)));
        bfu_reg_a   = `WORD_W'($urandom);
        bfu_reg_b   = ($urandom_range(0, 2) == 0) ? bfu_reg_a : `WORD_W'($urandom);
        bfu_current_pc = `WORD_W'($urandom) & ~`WORD_W'(3); // word aligned
        bfu_imm     = `WORD_W'($urandom_range(0, 511)) - `WORD_W'(256);
        bfu_predicted_outcome = 1'($urandom_range(0, 1));
        rd          = `REG_W'($urandom);
        sls_mem_type = ($urandom_range(0, 1) == 0) ? mem_load : mem_store;
        sls_rs1     = `WORD_W'($urandom);
        sls_rs2     = `WORD_W'($urandom);
        sls_imm     = `WORD_W'($urandom_range(0, 63));
        sls_enable  = !sls_busy && !ls_pend && ($urandom_range(0, 2) == 0);
        exp_alu_v    = salu_enable;
        exp_alu_res  = alu_ref(salu_aluop, salu_port_a, salu_port_b);
        exp_alu_ovf  = alu_ovf_ref(salu_aluop, salu_port_a, salu_port_b);
        exp_alu_rd   = rd;
        exp_alu_spec = spec;
        exp_br_v     = bfu_enable;
        exp_br_taken = branch_taken(bfu_branch_type, bfu_reg_a, bfu_reg_b);
        exp_br_link  = bfu_current_pc + `WORD_W'(4);
        if (!exp_br_taken) exp_br_pc = exp_br_link;
        else if (bfu_branch_type == br_jalr) exp_br_pc = (bfu_reg_a + bfu_imm) & ~`WORD_W'(1);
        else exp_br_pc = bfu_current_pc + bfu_imm;
        exp_br_miss  = exp_br_taken != bfu_predicted_outcome;
        exp_br_jump  = bfu_branch_type inside {br_jal, br_jalr};
        exp_br_rd    = rd;
        if (sls_enable) begin
            ls_pend    = 1'b1;
            ls_age     = 0;
            ls_load_e  = (sls_mem_type == mem_load);
            ls_addr_e  = sls_rs1 + sls_imm;
            ls_store_e = sls_rs2;
            ls_rd_e    = rd;
            if (ls_load_e) ls_data_e = model_mem[ls_addr_e[5:2]];
            else model_mem[ls_addr_e[5:2]] = sls_rs2; // later loads read it back
        end
    endtask

    task automatic drive_idle();
        salu_enable = 1'b0;
        bfu_enable  = 1'b0;
        sls_enable  = 1'b0;
        exp_alu_v   = 1'b0;
        exp_br_v    = 1'b0;
    endtask

    initial begin
        void'($urandom(23846));
        reset = 1'b1;
        dmem_load = '0;
        dhit = 1'b0;
        drive_random();
        drive_idle();
        salu_enable = 1'b1; // all units issued, reset alone keeps strobes low
        bfu_enable  = 1'b1;
        sls_enable  = 1'b1;
        ls_pend = 1'b0;
        for (int i = 0; i < 16; i++) model_mem[i] = fill_word(i);
        repeat (4) @(negedge CLK);
        check_reset_state();
        drive_idle();
        reset = 1'b0;
        for (cyc = 0; cyc < 2000 && !timed_out; cyc++) begin
            @(negedge CLK);
            check_alu();
            check_branch();
            check_ls();
            drive_random();
        end
        // drain the last load/store, bounded
        for (int n = 0; n < `MEM_TIMEOUT + 2 && (ls_pend || exp_alu_v || exp_br_v) &&
                 !timed_out; n++) begin
            @(negedge CLK);
            check_alu();
            check_branch();
            check_ls();
            drive_idle();
        end
        if (ls_pend && !timed_out) begin
            $display("timeout: load/store op still outstanding at the end of the run");
            timed_out = 1'b1;
        end
        if (squash_cnt == 0) begin
            err_other++;
            $display("no squashed alu result was exercised");
        end
        $display("errors: word %0d, tag %0d, bit %0d, other %0d (squashes %0d)",
                 err_word, err_tag, err_bit, err_other, squash_cnt);
        if (timed_out || err_word + err_tag + err_bit + err_other != 0) begin
            $display("TEST FAIL");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
execute_pkg.sv
fu_alu.sv
fu_branch.sv
fu_scalar_ls.sv
execute_ctrl.sv
execute.sv
tb_execute.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_execute -f sim.f -o tb_execute
	./obj_dir/tb_execute | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
